/* rtl/ifu_pkg.sv */
// Shared types for the instruction fetch front end: addresses, fetch packets and state enums
package ifu_pkg;

   // ****************************************
   // Address and data types
   // ****************************************

   typedef logic [31:1] fetch_addr_t;            // Halfword address, pc format
   typedef logic [31:2] word_addr_t;             // Word address into the ICCM
   typedef logic [31:0] fetch_word_t;            // One fetched word

   // One fetch buffer entry
   // addr and fault are known at request time, data arrives a cycle later
   typedef struct packed {
      word_addr_t  addr;                         // Word address of the fetch
      fetch_word_t data;                         // Returned ICCM data, zero on fault
      logic        fault;                        // Address outside the ICCM region
   } fetch_pkt_t;

   // ****************************************
   // State and opcode enums
   // ****************************************

   // Fetch control states
   typedef enum logic {
      FETCH_RUN  = 1'b0,                         // Issue sequential reads
      FETCH_HALT = 1'b1                          // Stopped by a no-redirect flush
   } fetch_state_e;

   // Instruction length as seen by the aligner
   typedef enum logic {
      INST_16 = 1'b0,                            // Compressed
      INST_32 = 1'b1                             // Full length, low bits 2'b11
   } inst_size_e;

endpackage

/* rtl/ifu_fetch_ctl.sv */
// Fetch control: address generation, flush redirect and halt, ICCM read strobe and region check
module ifu_fetch_ctl #(
   parameter logic [31:0]        RESET_VECTOR = 32'h0000_0000, // Byte address, word aligned
   parameter ifu_pkg::word_addr_t ICCM_BASE    = '0,           // First ICCM word
   parameter int unsigned        ICCM_WORDS   = 64             // ICCM size in words
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                exu_flush_final,          // Flush, redirect to path
   input  ifu_pkg::fetch_addr_t exu_flush_path_final,    // Flush target pc
   input  logic                dec_tlu_flush_noredir_wb, // Flush without refetch
   input  logic                fb_free,                  // Buffer can take one more read
   output logic                iccm_rden,                // ICCM read strobe
   output ifu_pkg::word_addr_t  iccm_rw_addr,             // ICCM word address
   output logic                fetch_req,                // Request pulse to the buffer
   output ifu_pkg::fetch_pkt_t  fetch_req_pkt             // Address and fault, no data yet
);

   localparam ifu_pkg::word_addr_t ICCM_SIZE = ifu_pkg::word_addr_t'(ICCM_WORDS);

   ifu_pkg::fetch_state_e state_q;                // Run or halt
   ifu_pkg::word_addr_t   fetch_addr_q;           // Next sequential word
   ifu_pkg::word_addr_t   cur_addr;               // Address used this cycle
   ifu_pkg::word_addr_t   region_off;             // Word offset into the ICCM
   logic                  fetch_run;              // Fetching is allowed this cycle
   logic                  in_region;              // Address hits the ICCM

   // ****************************************
   // Address select and request
   // ****************************************

   // A flush takes effect in its own cycle
   assign cur_addr  = exu_flush_final ? exu_flush_path_final[31:2] : fetch_addr_q;
   assign fetch_run = exu_flush_final ? ~dec_tlu_flush_noredir_wb
                                      : (state_q == ifu_pkg::FETCH_RUN);

   // The buffer drops everything on a flush, so free space is implied then
   assign fetch_req = ~rst & fetch_run & (exu_flush_final | fb_free);

   // Region check against base and size
   assign region_off = cur_addr - ICCM_BASE;
   assign in_region  = (cur_addr >= ICCM_BASE) & (region_off < ICCM_SIZE);

   assign iccm_rden    = fetch_req & in_region; // No read outside the ICCM
   assign iccm_rw_addr = cur_addr;

   always_comb begin
      fetch_req_pkt       = '0;
      fetch_req_pkt.addr  = cur_addr;
      fetch_req_pkt.fault = ~in_region;         // Faulted word still gets a slot
   end

   // ****************************************
   // State and address registers
   // ****************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q      <= ifu_pkg::FETCH_RUN;
         fetch_addr_q <= RESET_VECTOR[31:2];
      end else begin
         if (exu_flush_final) begin
            state_q <= dec_tlu_flush_noredir_wb ? ifu_pkg::FETCH_HALT
                                                : ifu_pkg::FETCH_RUN;
         end
         // Advance one word per request, else hold the selected address
         fetch_addr_q <= fetch_req ? cur_addr + 1'b1 : cur_addr;
      end
   end

endmodule

/* rtl/ifu_fetch_buf.sv */
// Fetch buffer: circular queue of fetched words with in-flight tracking and flush discard
module ifu_fetch_buf #(
   parameter int unsigned FB_DEPTH = 4                  // Entries, power of two
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               exu_flush_final,          // Drop all entries and the read in flight
   input  logic               fetch_req,                // Read issued this cycle
   input  ifu_pkg::fetch_pkt_t fetch_req_pkt,            // Address and fault of that read
   input  ifu_pkg::fetch_word_t iccm_rd_data,           // Data of last cycle's read
   input  logic               pop_one,                  // Aligner done with head
   input  logic               pop_two,                  // Aligner done with head and next
   output logic               fb_free,                  // Room for another read
   output ifu_pkg::fetch_pkt_t head_pkt,
   output logic               head_valid,
   output ifu_pkg::fetch_pkt_t next_pkt,
   output logic               next_valid
);

   localparam int PTR_W = (FB_DEPTH > 1) ? $clog2(FB_DEPTH) : 1;
   localparam int CNT_W = PTR_W + 1;

   ifu_pkg::fetch_pkt_t fb_mem [FB_DEPTH];        // Entry storage
   ifu_pkg::fetch_pkt_t pend_pkt_q;               // Request waiting for its data
   ifu_pkg::fetch_pkt_t wr_pkt;                   // Request merged with returned data
   logic                pend_q;                   // One read in flight
   logic                wr_en;                    // Write merged entry this cycle
   logic [PTR_W-1:0]    rd_ptr;
   logic [PTR_W-1:0]    wr_ptr;
   logic [CNT_W-1:0]    count;                    // Valid entries
   logic [CNT_W-1:0]    space;                    // Free entries
   logic [CNT_W-1:0]    pop_cnt;                  // Entries released by the aligner

   // ****************************************
   // Return merge and write
   // ****************************************

   assign wr_en = pend_q & ~exu_flush_final;    // Return of a flushed read is lost

   always_comb begin
      wr_pkt      = pend_pkt_q;
      wr_pkt.data = pend_pkt_q.fault ? '0 : iccm_rd_data; // No ICCM data for a fault
   end

   assign pop_cnt = pop_two ? CNT_W'(2) : (pop_one ? CNT_W'(1) : '0);

   // Free entries must cover the read in flight plus a new one
   assign space   = CNT_W'(FB_DEPTH) - count;
   assign fb_free = space > {{(CNT_W-1){1'b0}}, pend_q};

   // Head and second entry for the aligner
   assign head_pkt   = fb_mem[rd_ptr];
   assign next_pkt   = fb_mem[rd_ptr + 1'b1];
   assign head_valid = count != '0;
   assign next_valid = count > CNT_W'(1);

   // ****************************************
   // Control registers
   // ****************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         pend_q <= 1'b0;
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         pend_q <= fetch_req;                   // Flush-cycle request is kept
         if (exu_flush_final) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
         end else begin
            rd_ptr <= rd_ptr + PTR_W'(pop_cnt);
            wr_ptr <= wr_ptr + PTR_W'(wr_en);
            count  <= count + CNT_W'(wr_en) - pop_cnt;
         end
      end
   end

   // Payload, no reset
   always_ff @(posedge clk) begin
      if (fetch_req) pend_pkt_q <= fetch_req_pkt;
      if (wr_en) fb_mem[wr_ptr] <= wr_pkt;
   end

endmodule

/* rtl/ifu_aligner.sv */
// Aligner: cuts the fetched halfword stream into 16- and 32-bit instructions with fault flags
module ifu_aligner (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 exu_flush_final,        // Restart at a new offset
   input  ifu_pkg::fetch_addr_t exu_flush_path_final,   // Bit 1 gives the halfword offset
   input  ifu_pkg::fetch_pkt_t  head_pkt,               // Oldest buffered word
   input  logic                 head_valid,
   input  ifu_pkg::fetch_pkt_t  next_pkt,               // Word after head
   input  logic                 next_valid,
   input  logic                 dec_i0_decode_d,        // Decode takes the instruction
   output logic                 pop_one,                // Release head
   output logic                 pop_two,                // Release head and next
   output logic                 ifu_i0_valid,
   output ifu_pkg::fetch_word_t ifu_i0_instr,
   output ifu_pkg::fetch_addr_t ifu_i0_pc,
   output logic                 ifu_i0_pc4,             // 4-byte instruction
   output logic [15:0]          ifu_i0_cinst,           // Raw compressed instruction
   output logic                 ifu_i0_icaf,            // Access fault
   output logic                 ifu_i0_icaf_second      // Fault on upper half only
);

   ifu_pkg::inst_size_e size;                    // Length of the current instruction
   logic                off_q;                   // Halfword offset into head
   logic [15:0]         low_hw;                  // First halfword
   logic [15:0]         high_hw;                 // Second halfword of a 32-bit
   logic                straddle;                // Upper half lies in next word
   logic                second_fault;            // Upper half from a faulted word
   logic                consume;                 // Instruction accepted

   // ****************************************
   // Halfword select
   // ****************************************

   assign low_hw  = off_q ? head_pkt.data[31:16] : head_pkt.data[15:0];
   assign high_hw = off_q ? next_pkt.data[15:0] : head_pkt.data[31:16];

   // Faulted halfword always goes out as a 16-bit
   assign size = ((&low_hw[1:0]) & ~head_pkt.fault) ? ifu_pkg::INST_32 : ifu_pkg::INST_16;

   assign straddle     = off_q & (size == ifu_pkg::INST_32);
   assign second_fault = straddle & next_pkt.fault;

   // Needs the next word when straddling, blanked in the flush cycle
   assign ifu_i0_valid = head_valid & (~straddle | next_valid) & ~exu_flush_final;
   assign consume      = ifu_i0_valid & dec_i0_decode_d;

   // ****************************************
   // Decode outputs
   // ****************************************

   always_comb begin
      if (size == ifu_pkg::INST_32) begin
         ifu_i0_instr = {high_hw, low_hw};
         ifu_i0_cinst = '0;                     // Zero for 32-bit
      end else begin
         ifu_i0_instr = {16'h0000, low_hw};
         ifu_i0_cinst = low_hw;
      end
   end

   assign ifu_i0_pc          = {head_pkt.addr, off_q};
   assign ifu_i0_pc4         = size == ifu_pkg::INST_32;
   assign ifu_i0_icaf        = head_pkt.fault | second_fault;
   assign ifu_i0_icaf_second = second_fault;

   // ****************************************
   // Buffer pops and offset
   // ****************************************

   // Head is used up unless a 16-bit leaves its upper half
   // A faulted word behind a straddle holds no data and goes with the head
   assign pop_two = consume & second_fault;
   assign pop_one = consume & ~second_fault & (off_q | (size == ifu_pkg::INST_32));

   always_ff @(posedge clk) begin
      if (rst) begin
         off_q <= 1'b0;
      end else if (exu_flush_final) begin
         off_q <= exu_flush_path_final[1];
      end else if (consume) begin
         // 16-bit flips the offset, a straddle stays at 1 unless the rest is dropped
         if (size == ifu_pkg::INST_16) off_q <= ~off_q;
         else if (second_fault) off_q <= 1'b0;
      end
   end

endmodule

/* rtl/ifu_top.sv */
// Instruction fetch front end top: fetch control, fetch buffer and aligner
module ifu_top #(
   parameter logic [31:0]         RESET_VECTOR = 32'h0000_0000, // First fetch, byte address
   parameter ifu_pkg::word_addr_t ICCM_BASE    = '0,            // ICCM starts at word 0
   parameter int unsigned         ICCM_WORDS   = 64,            // 256 bytes of ICCM
   parameter int unsigned         FB_DEPTH     = 4              // Fetch buffer entries
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 exu_flush_final,
   input  ifu_pkg::fetch_addr_t exu_flush_path_final,
   input  logic                 dec_tlu_flush_noredir_wb,
   input  logic                 dec_i0_decode_d,
   output logic                 iccm_rden,
   output ifu_pkg::word_addr_t  iccm_rw_addr,
   input  ifu_pkg::fetch_word_t iccm_rd_data,           // One cycle after iccm_rden
   output logic                 ifu_i0_valid,
   output ifu_pkg::fetch_word_t ifu_i0_instr,
   output ifu_pkg::fetch_addr_t ifu_i0_pc,
   output logic                 ifu_i0_pc4,
   output logic [15:0]          ifu_i0_cinst,
   output logic                 ifu_i0_icaf,
   output logic                 ifu_i0_icaf_second
);

   logic                fb_free;                 // Buffer -> fetch control
   logic                fetch_req;               // Fetch control -> buffer
   ifu_pkg::fetch_pkt_t fetch_req_pkt;
   ifu_pkg::fetch_pkt_t head_pkt;                // Buffer -> aligner
   ifu_pkg::fetch_pkt_t next_pkt;
   logic                head_valid;
   logic                next_valid;
   logic                pop_one;                 // Aligner -> buffer
   logic                pop_two;

   ifu_fetch_ctl #(
      .RESET_VECTOR (RESET_VECTOR),
      .ICCM_BASE    (ICCM_BASE),
      .ICCM_WORDS   (ICCM_WORDS)
   ) ctl (.*);

   ifu_fetch_buf #(
      .FB_DEPTH (FB_DEPTH)
   ) fbuf (.*);

   ifu_aligner aln (.*);

endmodule

/* verif/ifu_props.sv */
// Fetch front end assertions: reset quiet, stable hold, flush blanking and fault flag rules
module ifu_props (
   input logic                 clk,
   input logic                 rst,
   input logic                 exu_flush_final,
   input logic                 dec_i0_decode_d,
   input logic                 iccm_rden,
   input logic                 ifu_i0_valid,
   input ifu_pkg::fetch_word_t ifu_i0_instr,
   input ifu_pkg::fetch_addr_t ifu_i0_pc,
   input logic                 ifu_i0_icaf,
   input logic                 ifu_i0_icaf_second
);
   timeunit 1ns;
   timeprecision 1ps;

   logic hold;                                    // Valid instruction not taken by decode

   assign hold = ifu_i0_valid & ~dec_i0_decode_d & ~exu_flush_final;

   a_reset_quiet: assert property (@(posedge clk)
      (rst && $past(rst)) |-> !ifu_i0_valid && !iccm_rden)
      else $error("valid or iccm_rden high during reset");

   a_hold_stable: assert property (@(posedge clk) disable iff (rst)
      ($past(hold) && !exu_flush_final)
      |-> ifu_i0_valid && $stable(ifu_i0_pc) && $stable(ifu_i0_instr))
      else $error("instruction changed while decode held it");

   a_flush_blank: assert property (@(posedge clk) disable iff (rst)
      exu_flush_final |=> !ifu_i0_valid)
      else $error("valid in the cycle after a flush");

   // Faulted second word brings no data into the upper half
   a_icaf_second: assert property (@(posedge clk) disable iff (rst)
      (ifu_i0_valid && ifu_i0_icaf_second)
      |-> ifu_i0_icaf && (ifu_i0_instr[31:16] == 16'h0000))
      else $error("icaf_second without icaf or with data in the upper half");

endmodule

bind ifu_top ifu_props props (.*);

/* verif/ifu_tb.sv */
// Fetch front end testbench: file driven scenarios, ICCM model, random decode stalls and checks
module ifu_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int TIMEOUT = 40;                   // Cycles to wait for one instruction

   logic clk, rst, exu_flush_final, dec_tlu_flush_noredir_wb, dec_i0_decode_d;
   ifu_pkg::fetch_addr_t exu_flush_path_final;
   logic                 iccm_rden;
   ifu_pkg::word_addr_t  iccm_rw_addr;
   ifu_pkg::fetch_word_t iccm_rd_data;
   logic                 ifu_i0_valid, ifu_i0_pc4, ifu_i0_icaf, ifu_i0_icaf_second;
   ifu_pkg::fetch_word_t ifu_i0_instr;
   ifu_pkg::fetch_addr_t ifu_i0_pc;
   logic [15:0]          ifu_i0_cinst;

   logic [31:0] iccm_mem [64];                    // ICCM contents
   logic [31:0] rd_q;                             // Read data in the ICCM pipe
   int          sc_kind[$], sc_rnd[$], sc_nexp[$];  // Scenario list
   logic [31:0] sc_path[$];
   logic [31:0] ex_pc[$], ex_instr[$];            // Expected stream
   logic [2:0]  ex_flags[$];
   logic [31:0] rng;
   int          errors, checks;
   bit          aborted;                          // A wait ran out

   ifu_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;                     // 100 ns period
   end

   // ****************************************
   // ICCM model, one cycle latency
   // ****************************************

   always @(posedge clk) if (iccm_rden) rd_q <= iccm_mem[iccm_rw_addr[7:2]];
   always @(negedge clk) iccm_rd_data <= rd_q;    // Valid the cycle after the strobe

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_pc(input ifu_pkg::fetch_addr_t got, input ifu_pkg::fetch_addr_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: pc %h expected %h", $time, {got, 1'b0}, {exp, 1'b0});
      end
   endtask

   task automatic check_instr(input ifu_pkg::fetch_word_t got, input ifu_pkg::fetch_word_t exp,
                              input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_fault(input logic [2:0] got, input logic [2:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: pc4/icaf/icaf_second %b expected %b", $time, got, exp);
      end
   endtask

   task automatic load_input();
      int          fd, n, i;
      string       line;
      logic [7:0]  tag;
      logic [31:0] a, b, c;
      for (i = 0; i < 64; i++) iccm_mem[i] = {10'd0, 6'(i), 10'd0, 6'(i)};  // Fill by address
      fd = $fopen("verif/ifu_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file verif/ifu_input.txt");
         errors++;
         aborted = 1'b1;
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
               n = $sscanf(line, "%s %h %h %h", tag, a, b, c);
               if (tag == "M") iccm_mem[a[5:0]] = b;
               else if (tag == "S") begin
                  sc_kind.push_back(int'(a));
                  sc_path.push_back(b);
                  sc_rnd.push_back(int'(c));
                  sc_nexp.push_back(0);
               end else if (tag == "E") begin
                  ex_pc.push_back(a);
                  ex_instr.push_back(b);
                  ex_flags.push_back(c[2:0]);
                  sc_nexp[sc_nexp.size()-1] = sc_nexp[sc_nexp.size()-1] + 1;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // ****************************************
   // Scenario tasks
   // ****************************************

   task automatic apply_flush(input logic [31:0] path, input logic noredir);
      @(negedge clk);
      exu_flush_final          = 1'b1;
      exu_flush_path_final     = path[31:1];
      dec_tlu_flush_noredir_wb = noredir;
      dec_i0_decode_d          = 1'b0;
      @(negedge clk);
      checks++;
      if (ifu_i0_valid) begin
         errors++;
         $display("CHECK FAILED at %0t: valid in the cycle after a flush", $time);
      end
      exu_flush_final          = 1'b0;
      dec_tlu_flush_noredir_wb = 1'b0;
   endtask

   task automatic check_halted();
      int i;
      for (i = 0; i < 20; i++) begin              // Fixed quiet window
         @(negedge clk);
         checks++;
         if (iccm_rden || ifu_i0_valid) begin
            errors++;
            $display("CHECK FAILED at %0t: fetch activity after a no-redirect flush", $time);
         end
      end
   endtask

   task automatic consume_stream(input int rnd, input int base, input int nexp, input bit exact);
      int          k, wait_cnt, lead;
      logic        d, taken;
      bit          first;
      logic [31:0] pc, exp_cinst;
      first = exact;
      // A 32-bit at an odd halfword path also needs the word fetched one cycle later
      lead  = (nexp > 0 && ex_pc[base][1] && ex_flags[base][2]) ? 1 : 0;
      for (k = 0; k < nexp && !aborted; k++) begin
         taken    = 1'b0;
         wait_cnt = 0;
         pc       = ex_pc[base+k];
         exp_cinst = ex_flags[base+k][2] ? 32'h0 : {16'h0, ex_instr[base+k][15:0]};
         while (!taken && !aborted) begin
            @(negedge clk);
            if (first) begin
               if (lead > 0) begin                // Second word still in flight
                  lead--;
               end else begin                     // First data cycle after the flush
                  checks++;
                  if (!ifu_i0_valid) begin
                     errors++;
                     $display("CHECK FAILED at %0t: first valid late after flush", $time);
                  end
                  first = 1'b0;
               end
            end
            rng = xorshift(rng);
            d   = (rnd != 0) ? (rng[1:0] != 2'b00) : 1'b1;  // Stall about one cycle in four
            dec_i0_decode_d = d;
            if (ifu_i0_valid && d) begin
               check_pc(ifu_i0_pc, pc[31:1]);
               check_instr(ifu_i0_instr, ex_instr[base+k], "instr");
               check_instr({16'h0, ifu_i0_cinst}, exp_cinst, "cinst");
               check_fault({ifu_i0_pc4, ifu_i0_icaf, ifu_i0_icaf_second}, ex_flags[base+k]);
               taken = 1'b1;
            end else begin
               wait_cnt++;
               if (wait_cnt > TIMEOUT) begin
                  $display("Timed out waiting for the instruction at pc %h", pc);
                  errors++;
                  aborted = 1'b1;
               end
            end
         end
      end
   endtask

   initial begin
      int s, base;
      rst = 1'b1;
      exu_flush_final = 1'b0;
      exu_flush_path_final = '0;
      dec_tlu_flush_noredir_wb = 1'b0;
      dec_i0_decode_d = 1'b0;
      iccm_rd_data = '0;
      rng = 32'hd0ba;
      errors = 0;
      checks = 0;
      aborted = 1'b0;
      load_input();
      repeat (3) @(posedge clk);                  // Reset held 3 cycles
      @(negedge clk);
      rst = 1'b0;
      base = 0;
      for (s = 0; s < sc_kind.size() && !aborted; s++) begin
         if (sc_kind[s] != 0) apply_flush(sc_path[s], sc_kind[s] == 2);
         if (sc_kind[s] == 2) check_halted();
         else consume_stream(sc_rnd[s], base, sc_nexp[s], sc_kind[s] == 1);
         base += sc_nexp[s];
      end
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0 && !aborted) $display("ALL TESTS PASSED");
      else $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

/* ifu_fetch.f */
rtl/ifu_pkg.sv
rtl/ifu_fetch_ctl.sv
rtl/ifu_fetch_buf.sv
rtl/ifu_aligner.sv
rtl/ifu_top.sv
verif/ifu_props.sv
verif/ifu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the fetch front end testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module ifu_tb -f ifu_fetch.f -o ifu_sim \
   || { echo "Build failed"; exit 1; }
./obj_dir/ifu_sim > sim.log 2>&1 || echo "Simulation exited with an error" >> sim.log
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "Simulation exited with an error" sim.log && { echo "RESULT: FAIL"; exit 1; }
echo "RESULT: PASS"
exit 0

/* verif/ifu_input.txt */
# M <word index> <data>                    : ICCM image, other words get a fill pattern
# S <kind 0 reset 1 flush 2 noredir> <flush byte addr> <random decode>
# E <pc byte addr> <instr> <flags: bit2 pc4, bit1 icaf, bit0 icaf_second>
M 00 00014501
M 01 00000513
M 02 07934585
M 03 80820010
M 04 00b50533
M 05 00000000
M 3f 05134501
S 0 00000000 0
E 00000000 00004501 0
E 00000002 00000001 0
E 00000004 00000513 4
E 00000008 00004585 0
E 0000000a 00100793 4
E 0000000e 00008082 0
E 00000010 00b50533 4
E 00000014 00000000 0
S 1 0000000a 1
E 0000000a 00100793 4
E 0000000e 00008082 0
E 00000010 00b50533 4
S 1 00000002 1
E 00000002 00000001 0
E 00000004 00000513 4
S 1 000000fc 1
E 000000fc 00004501 0
E 000000fe 00000513 7
E 00000104 00000000 2
E 00000106 00000000 2
S 2 00000000 0
S 1 00000010 1
E 00000010 00b50533 4
E 00000014 00000000 0
